// ==== common/mult_pkg.sv ====
`default_nettype none

package mult_pkg;

    // register and product widths
    localparam int XLEN   = 32;
    localparam int PROD_W = 2 * XLEN;

    // pipeline depth of the multiplier
    // must divide PROD_W evenly
    localparam int MULT_STAGES = 4;

    // multiplier bits retired by each stage
    localparam int STAGE_SHIFT = PROD_W / MULT_STAGES;

    // physical register tag and rob index widths
    localparam int TAG_W = 6;
    localparam int ROB_W = 5;

    // funct3 encodings of the rv32m multiply group
    typedef enum logic [2:0] {
        M_MUL    = 3'd0,
        M_MULH   = 3'd1,
        M_MULHSU = 3'd2,
        M_MULHU  = 3'd3
    } mult_func_t;

    // everything the issue logic hands to the unit
    typedef struct packed {
        mult_func_t        func;
        logic [XLEN-1:0]   rs1_value;
        logic [XLEN-1:0]   rs2_value;
        logic [TAG_W-1:0]  dest_tag;
        logic [ROB_W-1:0]  rob_idx;
    } issue_packet_t;

    // side-band data that follows an instruction down the pipe
    typedef struct packed {
        logic [TAG_W-1:0]  dest_tag;
        logic [ROB_W-1:0]  rob_idx;
    } tag_packet_t;

    // finished result as broadcast on the cdb
    typedef struct packed {
        logic [XLEN-1:0]   result;
        tag_packet_t       tags;
    } fu_packet_t;

endpackage

`default_nettype wire

// ==== mult/mult_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mult_stage import mult_pkg::*; (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              stall,
    input  wire logic              start,
    input  wire mult_func_t        func,
    input  wire logic [PROD_W-1:0] prev_sum,
    input  wire logic [PROD_W-1:0] mplier,
    input  wire logic [PROD_W-1:0] mcand,
    output logic      [PROD_W-1:0] product_sum,
    output logic      [PROD_W-1:0] next_mplier,
    output logic      [PROD_W-1:0] next_mcand,
    output mult_func_t             next_func,
    output logic                   done
);

    logic [PROD_W-1:0] partial_product;

    // low slice of the multiplier times the full multiplicand
    assign partial_product = mplier[STAGE_SHIFT-1:0] * mcand;

    // datapath registers, frozen while the result buffer is full
    always_ff @(posedge clock) begin
        if (!stall) begin
            product_sum <= prev_sum + partial_product;
            // drop the consumed slice, line the multiplicand up with the next one
            next_mplier <= mplier >> STAGE_SHIFT;
            next_mcand  <= mcand << STAGE_SHIFT;
            next_func   <= func;
        end
    end

    // valid bit for the data held in this stage
    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else if (!stall) begin
            done <= start;
        end
    end

endmodule

`default_nettype wire

// ==== mult/mult.sv ====
`timescale 1ns/1ps
`default_nettype none

module mult import mult_pkg::*; (
    input  wire logic          clock,
    input  wire logic          reset,
    input  wire logic          stall,
    input  wire logic          issue_valid,
    input  wire issue_packet_t issue,
    output fu_packet_t         result,
    output logic               data_ready
);

    // chain between stages, index 0 feeds the first stage
    // and index MULT_STAGES comes out of the last one
    logic [PROD_W-1:0] sum_chain    [MULT_STAGES+1];
    logic [PROD_W-1:0] mplier_chain [MULT_STAGES+1];
    logic [PROD_W-1:0] mcand_chain  [MULT_STAGES+1];
    mult_func_t        func_chain   [MULT_STAGES+1];
    logic              done_chain   [MULT_STAGES+1];

    logic [PROD_W-1:0] product;
    logic [XLEN-1:0]   rs1;
    logic [XLEN-1:0]   rs2;
    logic              rs1_signed;
    logic              rs2_signed;

    // tags of each in-flight instruction, slot i lines up with stage i
    tag_packet_t tag_pipe [MULT_STAGES];
    tag_packet_t tag_in;

    assign rs1 = issue.rs1_value;
    assign rs2 = issue.rs2_value;

    // operand extension to the full product width
    // multiplicand is signed for every op except mulhu
    assign rs1_signed = (issue.func == M_MUL) || (issue.func == M_MULH) ||
                        (issue.func == M_MULHSU);
    // multiplier is signed only for mul and mulh
    assign rs2_signed = (issue.func == M_MUL) || (issue.func == M_MULH);

    assign mcand_chain[0]  = {{XLEN{rs1_signed & rs1[XLEN-1]}}, rs1};
    assign mplier_chain[0] = {{XLEN{rs2_signed & rs2[XLEN-1]}}, rs2};

    // accumulation starts from zero
    assign sum_chain[0]  = '0;
    assign func_chain[0] = issue.func;
    assign done_chain[0] = issue_valid;

    // each stage's done starts the next one
    for (genvar i = 0; i < MULT_STAGES; i++) begin : g_stage
        mult_stage u_stage (
            .clock       (clock),
            .reset       (reset),
            .stall       (stall),
            .start       (done_chain[i]),
            .func        (func_chain[i]),
            .prev_sum    (sum_chain[i]),
            .mplier      (mplier_chain[i]),
            .mcand       (mcand_chain[i]),
            .product_sum (sum_chain[i+1]),
            .next_mplier (mplier_chain[i+1]),
            .next_mcand  (mcand_chain[i+1]),
            .next_func   (func_chain[i+1]),
            .done        (done_chain[i+1])
        );
    end

    // empty slots carry zero tags
    assign tag_in = issue_valid ? tag_packet_t'{issue.dest_tag, issue.rob_idx} : '0;

    // tag shift register, moves in lockstep with the stage registers
    always_ff @(posedge clock) begin
        if (!stall) begin
            tag_pipe[0] <= tag_in;
            for (int i = 1; i < MULT_STAGES; i++) begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    assign product    = sum_chain[MULT_STAGES];
    assign data_ready = done_chain[MULT_STAGES];

    // mul keeps the low word, the mulh variants the high word
    always_comb begin
        if (func_chain[MULT_STAGES] == M_MUL) begin
            result.result = product[XLEN-1:0];
        end else begin
            result.result = product[PROD_W-1:XLEN];
        end
        result.tags = tag_pipe[MULT_STAGES-1];
    end

endmodule

`default_nettype wire

// ==== rtl/cdb_result_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdb_result_buffer import mult_pkg::*; (
    input  wire logic       clock,
    input  wire logic       reset,
    input  wire logic       data_ready,
    input  wire fu_packet_t result,
    input  wire logic       cdb_ready,
    output logic            stall,
    output logic            cdb_valid,
    output fu_packet_t      cdb
);

    // two slots, so one-bit pointers wrap on their own
    fu_packet_t entries [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;

    logic push;
    logic pop;

    // head entry goes straight out to the bus
    assign cdb_valid = (count != 2'd0);
    assign cdb       = entries[rd_ptr];

    assign pop = cdb_valid && cdb_ready;

    // full with nothing leaving this cycle, so the pipe must freeze
    // combinational from cdb_ready through pop
    assign stall = (count == 2'd2) && !pop;

    assign push = data_ready && !stall;

    // storage, no reset needed since count guards the reads
    // when full and popping, wr_ptr equals rd_ptr and the head is
    // replaced on the same edge it leaves
    always_ff @(posedge clock) begin
        if (push) begin
            entries[wr_ptr] <= result;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            // push and pop together leave count alone
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mult_fu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mult_fu_top import mult_pkg::*; (
    input  wire logic          clock,
    input  wire logic          reset,
    input  wire logic          issue_valid,
    input  wire issue_packet_t issue,
    input  wire logic          cdb_ready,
    output logic               issue_ready,
    output logic               cdb_valid,
    output fu_packet_t         cdb
);

    // multiplier to result buffer
    fu_packet_t mult_result;
    logic       data_ready;
    logic       stall;

    // nothing new enters while the pipe is frozen
    assign issue_ready = ~stall;

    // pipelined multiplier, tags ride along beside the data
    mult u_mult (
        .clock       (clock),
        .reset       (reset),
        .stall       (stall),
        .issue_valid (issue_valid),
        .issue       (issue),
        .result      (mult_result),
        .data_ready  (data_ready)
    );

    // holds finished results until the cdb takes them
    cdb_result_buffer u_result_buffer (
        .clock      (clock),
        .reset      (reset),
        .data_ready (data_ready),
        .result     (mult_result),
        .cdb_ready  (cdb_ready),
        .stall      (stall),
        .cdb_valid  (cdb_valid),
        .cdb        (cdb)
    );

endmodule

`default_nettype wire

// ==== bench/mult_fu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mult_fu_tb import mult_pkg::*; ();

    localparam int CLK_PERIOD    = 40;
    localparam int RANDOM_CYCLES = 800;
    localparam int WAIT_LIMIT    = 200;

    logic          clock;
    logic          reset;
    logic          issue_valid;
    issue_packet_t issue;
    logic          cdb_ready;
    logic          issue_ready;
    logic          cdb_valid;
    fu_packet_t    cdb;

    // expected cdb packets, oldest first
    fu_packet_t expected_q [$];

    integer      seed = 32'hea5e;
    int          data_errors;
    int          protocol_errors;
    int          timeout_errors;
    int          issued;
    int          transfers;
    int          packet_seq;
    logic        accepted;
    logic        transferred;
    logic        hold_seen;
    fu_packet_t  held_cdb;
    logic [31:0] corners [5];

    mult_fu_top uut (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue       (issue),
        .cdb_ready   (cdb_ready),
        .issue_ready (issue_ready),
        .cdb_valid   (cdb_valid),
        .cdb         (cdb)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // reference result from plain 64-bit integer arithmetic
    function automatic logic [XLEN-1:0] model_result(mult_func_t func, logic [31:0] a,
                                                     logic [31:0] b);
        longint sa;
        longint sb;
        longint za;
        longint zb;
        longint prod;
        sa = $signed(a);
        sb = $signed(b);
        za = a;
        zb = b;
        case (func)
            M_MUL:    prod = sa * sb;
            M_MULH:   prod = sa * sb;
            M_MULHSU: prod = sa * zb;
            default:  prod = za * zb;
        endcase
        // only mul wants the low word
        if (func == M_MUL) begin
            return prod[31:0];
        end
        return prod[63:32];
    endfunction

    function automatic logic chance(int pct);
        logic [31:0] r;
        r = $random(seed);
        return (r % 100) < pct;
    endfunction

    // mostly random words, now and then a corner value
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = $random(seed);
        if (r[3:0] == 4'd0) begin
            return corners[r[10:4] % 5];
        end
        return $random(seed);
    endfunction

    // rob index counts up so that ordering slips show in the tags
    function automatic issue_packet_t make_packet(mult_func_t func, logic [31:0] a,
                                                  logic [31:0] b);
        issue_packet_t pkt;
        logic [31:0]   r;
        r = $random(seed);
        pkt.func      = func;
        pkt.rs1_value = a;
        pkt.rs2_value = b;
        pkt.dest_tag  = r[TAG_W-1:0];
        pkt.rob_idx   = packet_seq[ROB_W-1:0];
        packet_seq++;
        return pkt;
    endfunction

    task automatic finish_run();
        $display("errors: data %0d, protocol %0d, timeout %0d (issued %0d, transferred %0d)",
                 data_errors, protocol_errors, timeout_errors, issued, transfers);
        if (data_errors + protocol_errors + timeout_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(string what);
        $display("timeout while waiting for %s", what);
        timeout_errors++;
        finish_run();
    endtask

    // one rising edge; everything read here is what that edge saw
    task automatic sample_edge();
        fu_packet_t expected;
        @(posedge clock);
        accepted    = issue_valid && issue_ready;
        transferred = cdb_valid && cdb_ready;
        // a stalled cdb packet must not move
        if (hold_seen) begin
            if (!cdb_valid) begin
                $display("cdb_valid dropped before the cdb took the result");
                protocol_errors++;
            end else if (cdb !== held_cdb) begin
                $display("FAILED cdb while stalled: expected %h got %h", held_cdb, cdb);
                protocol_errors++;
            end
        end
        hold_seen = cdb_valid && !cdb_ready;
        held_cdb  = cdb;
        if (accepted) begin
            expected.result        = model_result(issue.func, issue.rs1_value,
                                                  issue.rs2_value);
            expected.tags.dest_tag = issue.dest_tag;
            expected.tags.rob_idx  = issue.rob_idx;
            expected_q.push_back(expected);
            issued++;
        end
        if (transferred) begin
            transfers++;
            if (expected_q.size() == 0) begin
                $display("result transferred on the cdb with no instruction outstanding");
                data_errors++;
            end else begin
                expected = expected_q.pop_front();
                if (cdb.result !== expected.result) begin
                    $display("FAILED cdb.result: expected %h got %h",
                             expected.result, cdb.result);
                    data_errors++;
                end
                if (cdb.tags.dest_tag !== expected.tags.dest_tag) begin
                    $display("FAILED cdb.tags.dest_tag: expected %h got %h",
                             expected.tags.dest_tag, cdb.tags.dest_tag);
                    data_errors++;
                end
                if (cdb.tags.rob_idx !== expected.tags.rob_idx) begin
                    $display("FAILED cdb.tags.rob_idx: expected %h got %h",
                             expected.tags.rob_idx, cdb.tags.rob_idx);
                    data_errors++;
                end
            end
        end
    endtask

    // empty the pipe with cdb_ready high, a pending issue is kept until taken
    // stops once the cdb has sat idle for longer than the issue to cdb latency
    task automatic drain();
        int waited;
        int quiet;
        cdb_ready <= 1'b1;
        if (accepted) begin
            issue_valid <= 1'b0;
        end
        waited = 0;
        quiet  = 0;
        while (quiet < MULT_STAGES + 2 && waited < WAIT_LIMIT) begin
            sample_edge();
            if (accepted) begin
                issue_valid <= 1'b0;
            end
            if (cdb_valid || (issue_valid && !accepted)) begin
                quiet = 0;
            end else begin
                quiet++;
            end
            waited++;
        end
        if (quiet < MULT_STAGES + 2) begin
            report_timeout("the result buffer to drain");
        end
    endtask

    // lone issue into an empty unit, cdb_valid must rise MULT_STAGES edges later
    task automatic check_latency(issue_packet_t pkt);
        int edges;
        issue_valid <= 1'b1;
        issue       <= pkt;
        cdb_ready   <= 1'b1;
        sample_edge();
        if (!accepted) begin
            $display("isolated issue was not accepted by an empty unit");
            protocol_errors++;
        end
        issue_valid <= 1'b0;
        edges = 0;
        // first sample with cdb_valid high sees the edge after it rose
        do begin
            sample_edge();
            edges++;
        end while (!cdb_valid && edges < WAIT_LIMIT);
        if (!cdb_valid) begin
            report_timeout("cdb_valid after an isolated issue");
        end
        if (edges != MULT_STAGES + 1) begin
            $display("FAILED issue to cdb_valid edges: expected %h got %h",
                     MULT_STAGES + 1, edges);
            protocol_errors++;
        end
    endtask

    initial begin
        mult_func_t f;
        logic [31:0] r;
        corners = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                    32'h8000_0000, 32'h7fff_ffff};
        reset           = 1'b1;
        issue_valid     = 1'b0;
        issue           = '0;
        cdb_ready       = 1'b0;
        data_errors     = 0;
        protocol_errors = 0;
        timeout_errors  = 0;
        issued          = 0;
        transfers       = 0;
        packet_seq      = 0;
        accepted        = 1'b0;
        transferred     = 1'b0;
        hold_seen       = 1'b0;
        held_cdb        = '0;

        repeat (3) @(posedge clock);
        reset <= 1'b0;

        // state right out of reset
        sample_edge();
        if (cdb_valid !== 1'b0) begin
            $display("FAILED cdb_valid after reset: expected %h got %h", 1'b0, cdb_valid);
            protocol_errors++;
        end
        if (issue_ready !== 1'b1) begin
            $display("FAILED issue_ready after reset: expected %h got %h", 1'b1, issue_ready);
            protocol_errors++;
        end

        // every op on every corner pair, back to back with the cdb always ready
        cdb_ready <= 1'b1;
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    f = mult_func_t'(k);
                    issue_valid <= 1'b1;
                    issue       <= make_packet(f, corners[i], corners[j]);
                    sample_edge();
                    if (!accepted) begin
                        $display("issue_ready dropped during back-to-back issue");
                        protocol_errors++;
                    end
                end
            end
        end
        drain();

        check_latency(make_packet(M_MULHSU, 32'h8000_0000, 32'hffff_fffe));
        drain();

        // random issue against random cdb back-pressure
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            cdb_ready <= chance(60);
            // a refused packet stays on the bus untouched
            if (!(issue_valid && !accepted)) begin
                r = $random(seed);
                f = mult_func_t'({1'b0, r[1:0]});
                issue_valid <= chance(70);
                issue       <= make_packet(f, pick_operand(), pick_operand());
            end
            sample_edge();
        end
        drain();

        if (expected_q.size() != 0) begin
            $display("%0d results never reached the cdb", expected_q.size());
            data_errors++;
        end
        if (issued != transfers) begin
            $display("FAILED transfer count: expected %h got %h", issued, transfers);
            data_errors++;
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== sim.f ====
common/mult_pkg.sv
mult/mult_stage.sv
mult/mult.sv
rtl/cdb_result_buffer.sv
rtl/mult_fu_top.sv
bench/mult_fu_tb.sv

// ==== Bender.yml ====
package:
  name: mult_fu

sources:
  - common/mult_pkg.sv
  - mult/mult_stage.sv
  - mult/mult.sv
  - rtl/cdb_result_buffer.sv
  - rtl/mult_fu_top.sv
  - target: simulation
    files:
      - bench/mult_fu_tb.sv
